// ==== Makefile ====
# Verilator simulation of the macro-op fusion stage

VERILATOR ?= verilator
TOP       ?= fusionTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
+incdir+.
fusionPkg.sv
macroFuser.sv
uopQueue.sv
issueStage.sv
fusionTop.sv
tbClock.sv
fusion_chk.sv
fusionTb.sv

// ==== fusionPkg.sv ====
`include "fusion_defines.svh"

package fusionPkg;

    localparam int QIDX_W = $clog2(`FUSE_DEPTH);

    typedef logic [4:0]  regIdxT;
    typedef logic [31:0] immT;
    typedef logic [31:0] pcT;
    typedef logic [4:0]  fetchIdT;
    typedef logic [2:0]  fetchOffsT;

    typedef enum logic [1:0] {
        FU_INT,
        FU_LSU,
        FU_MUL
    } fuT;

    typedef enum logic [4:0] {
        INT_ADD,
        INT_LUI,
        INT_AUIPC,
        INT_SUB,
        // Conditional branches
        INT_BEQ,
        INT_BNE,
        INT_BLT,
        INT_BGE,
        INT_BLTU,
        INT_BGEU,
        // ADDI fused with the branch that follows it
        INT_F_ADDI_BEQ,
        INT_F_ADDI_BNE,
        INT_F_ADDI_BLT,
        INT_F_ADDI_BGE,
        INT_F_ADDI_BLTU,
        INT_F_ADDI_BGEU
    } intOpT;

    typedef struct packed {
        logic      valid;
        fuT        fu;
        intOpT     opcode;
        regIdxT    rd;
        regIdxT    rs0;
        regIdxT    rs1;
        logic      immB;
        immT       imm;
        pcT        pc;
        fetchIdT   fetchId;
        fetchOffsT fetchOffs;
        logic      compressed;
    } uopT;

    // Slot 0 holds the oldest op
    typedef uopT [`FUSE_WIDTH-1:0] uopBeatT;

    // Extra top bit is the wrap bit of the queue pointers
    typedef logic [QIDX_W:0] queueCntT;

endpackage

// ==== fusionTb.sv ====
`timescale 1ns/1ns
`include "fusion_defines.svh"

module fusionTb import fusionPkg::*; ();

    localparam int numCycles     = 3000;
    localparam int timeoutCycles = 4000 + 2 * numCycles;

    logic    clk;
    logic    rst;
    logic    flush;
    logic    outEn;
    logic    full;
    uopBeatT inUops;
    uopBeatT outUops;

    // Reference model state
    uopT  expQ[$];
    uopT  genQ[$];
    uopT  pend;
    bit   pendValid;
    bit   linked;
    bit   enPrev;
    bit   enState;
    bit   sawFull;
    int   enRun;
    int   cycleCnt = 0;

    tbClock #(.periodNs(40), .resetCycles(5)) uClock (.clk(clk), .rst(rst));

    fusionTop dut (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .outEn   (outEn),
        .inUops  (inUops),
        .full    (full),
        .outUops (outUops)
    );

    task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic compareUop(input uopT got, input uopT exp);
        checkEq(64'(got.fu), 64'(exp.fu), "fu");
        checkEq(64'(got.opcode), 64'(exp.opcode), "opcode");
        checkEq(64'(got.rd), 64'(exp.rd), "rd");
        checkEq(64'(got.rs0), 64'(exp.rs0), "rs0");
        checkEq(64'(got.rs1), 64'(exp.rs1), "rs1");
        checkEq(64'(got.immB), 64'(exp.immB), "immB");
        checkEq(64'(got.imm), 64'(exp.imm), "imm");
        checkEq(64'(got.pc), 64'(exp.pc), "pc");
        checkEq(64'(got.fetchId), 64'(exp.fetchId), "fetchId");
        checkEq(64'(got.fetchOffs), 64'(exp.fetchOffs), "fetchOffs");
        checkEq(64'(got.compressed), 64'(exp.compressed), "compressed");
    endtask

    function automatic intOpT pickOp(input int k);
        case (k)
            0:       return INT_ADD;
            1:       return INT_LUI;
            2:       return INT_AUIPC;
            3:       return INT_SUB;
            4:       return INT_BEQ;
            5:       return INT_BNE;
            6:       return INT_BLT;
            7:       return INT_BGE;
            8:       return INT_BLTU;
            default: return INT_BGEU;
        endcase
    endfunction

    function automatic uopT baseOp();
        uopT op;
        op = '0;
        op.valid = 1'b1;
        op.fu = FU_INT;
        op.opcode = INT_SUB;
        op.rd = 5'($urandom % 4);
        op.rs0 = 5'($urandom % 4);
        op.rs1 = 5'($urandom % 4);
        op.immB = 1'($urandom);
        op.imm = $urandom;
        op.pc = $urandom;
        op.fetchId = 5'($urandom);
        op.fetchOffs = 3'($urandom);
        op.compressed = 1'($urandom);
        return op;
    endfunction

    // Fusible pairs, a chain of three, near-misses and plain ops
    function automatic void refillGen();
        uopT    a;
        uopT    b;
        uopT    c;
        regIdxT x;
        int     r;
        a = baseOp();
        b = baseOp();
        c = baseOp();
        x = 5'($urandom % 3 + 1);
        r = int'($urandom % 100);
        a.opcode = ($urandom % 2 == 0) ? INT_LUI : INT_AUIPC;
        a.rd = x;
        b.opcode = INT_ADD;
        b.immB = 1'b1;
        b.rd = x;
        b.rs0 = x;
        c.opcode = pickOp(4 + int'($urandom % 6));
        c.rs0 = x;
        if (r < 20) begin
            genQ.push_back(a);
            genQ.push_back(b);
        end else if (r < 40) begin
            genQ.push_back(b);
            genQ.push_back(c);
        end else if (r < 48) begin
            genQ.push_back(a);
            genQ.push_back(b);
            genQ.push_back(c);
        end else if (r < 70) begin
            case ($urandom % 3)
                0:       b.rs0 = x ^ 5'h8;
                1:       b.immB = 1'b0;
                default: b.fu = FU_MUL;
            endcase
            if ($urandom % 2 == 0) begin
                genQ.push_back(a);
            end
            genQ.push_back(b);
            genQ.push_back(c);
        end else begin
            a = baseOp();
            a.opcode = pickOp(int'($urandom % 10));
            if ($urandom % 5 == 0) begin
                a.fu = ($urandom % 2 == 0) ? FU_LSU : FU_MUL;
            end
            genQ.push_back(a);
        end
    endfunction

    function automatic uopBeatT makeBeat();
        uopBeatT b;
        b = '0;
        if ($urandom % 10 == 0) begin
            return b;
        end
        for (int i = 0; i < `FUSE_WIDTH; i++) begin
            if ($urandom % 8 != 0) begin
                if (genQ.size() == 0) begin
                    refillGen();
                end
                b[i] = genQ.pop_front();
            end
        end
        return b;
    endfunction

    function automatic bit ruleA(uopT a, uopT b);
        return a.fu == FU_INT && b.fu == FU_INT && a.opcode inside {INT_LUI, INT_AUIPC}
            && b.opcode == INT_ADD && b.immB == 1'b1 && b.rd == a.rd && b.rs0 == b.rd;
    endfunction

    function automatic bit ruleB(uopT a, uopT b);
        return a.fu == FU_INT && b.fu == FU_INT && a.opcode == INT_ADD && a.immB == 1'b1
            && a.rs0 == a.rd && b.opcode inside {[INT_BEQ:INT_BGEU]} && b.rs0 == a.rd;
    endfunction

    // One slot of the stream, greedy oldest first
    function automatic void takeSlot(uopT s);
        uopT f;
        if (!s.valid) begin
            if (pendValid) expQ.push_back(pend);
            pendValid = 1'b0;
        end else if (pendValid && ruleA(pend, s)) begin
            f = pend;
            f.opcode = INT_ADD;
            f.imm = {pend.imm[31:12], 12'h000} + immT'($signed(s.imm[11:0]));
            expQ.push_back(f);
            pendValid = 1'b0;
        end else if (pendValid && ruleB(pend, s)) begin
            f = s;
            f.fu = pend.fu;
            f.opcode = intOpT'(INT_F_ADDI_BEQ + (s.opcode - INT_BEQ));
            f.rd = pend.rd;
            f.immB = 1'b0;
            f.imm = {pend.imm[11:0], 7'd0, s.imm[12:0]};
            expQ.push_back(f);
            pendValid = 1'b0;
        end else begin
            if (pendValid) expQ.push_back(pend);
            pend = s;
            pendValid = 1'b1;
        end
    endfunction

    task automatic checkOutputs();
        bit gap;
        gap = 1'b0;
        for (int i = 0; i < `FUSE_WIDTH; i++) begin
            if (!enPrev) checkEq(64'(outUops[i].valid), 64'(0), "valid while outEn low");
            if (outUops[i].valid) begin
                checkEq(64'(gap), 64'(0), "output slots not packed from slot 0");
                checkEq(64'(expQ.size() != 0), 64'(1), "output op with none expected");
                compareUop(outUops[i], expQ.pop_front());
            end else begin
                gap = 1'b1;
            end
        end
    endtask

    // Values read here are the ones before the edge
    task automatic stepEdge(input bit active);
        bit      fullNow;
        bit      flushNow;
        bit      taken;
        uopBeatT beatNow;
        fullNow = full;
        flushNow = flush;
        beatNow = inUops;
        checkOutputs();
        enPrev = outEn;
        if (fullNow) begin
            sawFull = 1'b1;
        end
        taken = 1'b1;
        if (flushNow) begin
            expQ.delete();
            pendValid = 1'b0;
            linked = 1'b0;
        end else if (!fullNow) begin
            if (!linked) takeSlot('0);
            for (int i = 0; i < `FUSE_WIDTH; i++) begin
                takeSlot(beatNow[i]);
            end
            linked = 1'b1;
        end else begin
            linked = 1'b0;
            taken = 1'b0;
        end
        if (active) begin
            if (taken) inUops <= makeBeat();
            flush <= !flushNow && ($urandom % 120 == 0);
            if (enRun == 0) begin
                enState = ($urandom % 10 >= 3);
                enRun = enState ? 5 + int'($urandom % 25) : 10 + int'($urandom % 30);
            end
            enRun = enRun - 1;
            outEn <= enState;
        end else begin
            inUops <= '0;
            flush <= 1'b0;
            outEn <= 1'b1;
        end
    endtask

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= timeoutCycles) begin
            $display("Test failures found");
            $fatal(1, "Timeout: the run did not finish within %0d cycles", timeoutCycles);
        end
    end

    initial begin
        void'($urandom(35));
        inUops = '0;
        outEn = 1'b0;
        flush = 1'b0;
        pendValid = 1'b0;
        linked = 1'b0;
        enPrev = 1'b0;
        enState = 1'b0;
        sawFull = 1'b0;
        enRun = 0;
        do @(posedge clk); while (rst);
        checkEq(64'(full), 64'(0), "full after reset");
        for (int i = 0; i < `FUSE_WIDTH; i++) begin
            checkEq(64'(outUops[i].valid), 64'(0), "outUops valid after reset");
        end
        stepEdge(1'b1);
        for (int c = 1; c < numCycles; c++) begin
            @(posedge clk);
            stepEdge(1'b1);
        end
        while (expQ.size() != 0 || pendValid) begin
            @(posedge clk);
            stepEdge(1'b0);
        end
        // Any extra op showing up now has no expected entry
        repeat (8) begin
            @(posedge clk);
            stepEdge(1'b0);
        end
        // Long outEn low runs must have filled the queue at least once
        checkEq(64'(sawFull), 64'(1), "full never rose under back-pressure");
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== fusionTop.sv ====
`timescale 1ns/1ns

module fusionTop import fusionPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    input  logic    outEn,
    input  uopBeatT inUops,
    output logic    full,
    output uopBeatT outUops
);

    uopBeatT  insBeat;
    uopBeatT  headUops;
    queueCntT popCnt;

    macroFuser uFuser (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .full    (full),
        .inUops  (inUops),
        .insBeat (insBeat)
    );

    uopQueue uQueue (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .insBeat  (insBeat),
        .popCnt   (popCnt),
        .headUops (headUops),
        .full     (full)
    );

    issueStage uIssue (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .outEn    (outEn),
        .headUops (headUops),
        .popCnt   (popCnt),
        .outUops  (outUops)
    );

endmodule

// ==== fusion_chk.sv ====
`timescale 1ns/1ns
`include "fusion_defines.svh"

module fusionChk import fusionPkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     flush,
    input logic     full,
    input uopBeatT  winQ,
    input uopBeatT  insQ,
    input uopBeatT  headUops,
    input uopBeatT  outUops,
    input queueCntT popCnt
);

    logic [`FUSE_WIDTH-1:0] outValid;
    logic                   headRun;
    queueCntT               headCnt;

    // Head entries only count while contiguous from slot 0
    always_comb begin
        headCnt = '0;
        headRun = 1'b1;
        for (int i = 0; i < `FUSE_WIDTH; i++) begin
            outValid[i] = outUops[i].valid;
            headRun = headRun && headUops[i].valid;
            if (headRun) begin
                headCnt = headCnt + queueCntT'(1);
            end
        end
    end

    assert property (@(posedge clk) (rst || flush) |=> outValid == '0)
        else $error("outUops valid bit set in the cycle after reset or flush");

    // Neither fuser register takes a new beat while full is high
    assert property (@(posedge clk) disable iff (rst)
        full && !flush |=> $stable(winQ) && $stable(insQ))
        else $error("fuser accepted a beat while full is high");

    assert property (@(posedge clk) disable iff (rst) popCnt <= headCnt)
        else $error("popCnt exceeds the valid head entries");

endmodule

bind fusionTop fusionChk uChk (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .full     (full),
    .winQ     (uFuser.winQ),
    .insQ     (uFuser.insQ),
    .headUops (headUops),
    .outUops  (outUops),
    .popCnt   (popCnt)
);

// ==== fusion_defines.svh ====
`ifndef FUSION_DEFINES_SVH
`define FUSION_DEFINES_SVH

// Micro-op slots per beat, same on the decoder side and the issue side
`define FUSE_WIDTH 4

// Fused op buffer entries, must be a power of two
`define FUSE_DEPTH 16

// Free entries needed to keep full low.
// Window and insert registers can still hold two beats when full rises
`define FUSE_MARGIN 8

`endif

// ==== issueStage.sv ====
`timescale 1ns/1ns
`include "fusion_defines.svh"

module issueStage import fusionPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     outEn,
    input  uopBeatT  headUops,
    output queueCntT popCnt,
    output uopBeatT  outUops
);

    queueCntT headCnt;

    // Head valid bits are contiguous from slot 0
    always_comb begin
        headCnt = '0;
        for (int i = 0; i < `FUSE_WIDTH; i++) begin
            if (headUops[i].valid) begin
                headCnt = headCnt + queueCntT'(1);
            end
        end
    end

    assign popCnt = outEn ? headCnt : '0;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < `FUSE_WIDTH; i++) begin
                outUops[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `FUSE_WIDTH; i++) begin
                outUops[i] <= headUops[i];
                outUops[i].valid <= outEn && headUops[i].valid;
            end
        end
    end

endmodule

// ==== macroFuser.sv ====
`timescale 1ns/1ns
`include "fusion_defines.svh"

module macroFuser import fusionPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    input  logic    full,
    input  uopBeatT inUops,
    output uopBeatT insBeat
);

    uopBeatT winQ;
    uopBeatT insQ;
    logic    winLinked;

    uopT [`FUSE_WIDTH:0] win;
    uopT [`FUSE_WIDTH:0] fusedWin;
    uopBeatT insNext;
    uopBeatT winNext;
    logic    prevFused;

    function automatic logic isBranch(intOpT op);
        return op inside {INT_BEQ, INT_BNE, INT_BLT, INT_BGE, INT_BLTU, INT_BGEU};
    endfunction

    // LUI/AUIPC followed by ADDI into the same register
    function automatic logic isRuleA(uopT a, uopT b);
        return a.valid && b.valid && a.fu == FU_INT && b.fu == FU_INT
            && (a.opcode == INT_LUI || a.opcode == INT_AUIPC)
            && b.opcode == INT_ADD && b.immB
            && b.rs0 == b.rd && a.rd == b.rd;
    endfunction

    // ADDI rd,rd,imm followed by a branch on rd
    function automatic logic isRuleB(uopT a, uopT b);
        return a.valid && b.valid && a.fu == FU_INT && b.fu == FU_INT
            && a.opcode == INT_ADD && a.immB && a.rs0 == a.rd
            && isBranch(b.opcode) && b.rs0 == a.rd;
    endfunction

    function automatic uopT fuseA(uopT a, uopT b);
        uopT r;
        r = a;
        r.opcode = INT_ADD;
        r.imm = {a.imm[31:12], 12'b0} + {{20{b.imm[11]}}, b.imm[11:0]};
        return r;
    endfunction

    function automatic intOpT fusedBranchOp(intOpT op);
        case (op)
            INT_BNE:  return INT_F_ADDI_BNE;
            INT_BLT:  return INT_F_ADDI_BLT;
            INT_BGE:  return INT_F_ADDI_BGE;
            INT_BLTU: return INT_F_ADDI_BLTU;
            INT_BGEU: return INT_F_ADDI_BGEU;
            default:  return INT_F_ADDI_BEQ;
        endcase
    endfunction

    function automatic uopT fuseB(uopT a, uopT b);
        uopT r;
        r = a;
        r.opcode = fusedBranchOp(b.opcode);
        // ADDI immediate on top, branch offset in the low bits
        r.imm = {a.imm[11:0], 7'b0, b.imm[12:0]};
        r.rs0 = b.rs0;
        r.rs1 = b.rs1;
        r.rd = a.rd;
        r.immB = 1'b0;
        // Branch prediction needs the branch's own location
        r.pc = b.pc;
        r.fetchId = b.fetchId;
        r.fetchOffs = b.fetchOffs;
        r.compressed = b.compressed;
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < `FUSE_WIDTH; i++) begin
            win[i] = winQ[i];
        end
        // Incoming slot 0 only counts when it follows the window directly
        win[`FUSE_WIDTH] = inUops[0];
        win[`FUSE_WIDTH].valid = inUops[0].valid && winLinked;

        fusedWin = win;
        prevFused = 1'b0;
        for (int i = 0; i < `FUSE_WIDTH; i++) begin
            if (!prevFused && isRuleA(win[i], win[i+1])) begin
                fusedWin[i] = fuseA(win[i], win[i+1]);
                fusedWin[i+1].valid = 1'b0;
                prevFused = 1'b1;
            end else if (!prevFused && isRuleB(win[i], win[i+1])) begin
                fusedWin[i] = fuseB(win[i], win[i+1]);
                fusedWin[i+1].valid = 1'b0;
                prevFused = 1'b1;
            end else begin
                prevFused = 1'b0;
            end
        end

        for (int i = 0; i < `FUSE_WIDTH; i++) begin
            insNext[i] = fusedWin[i];
        end
        winNext = inUops;
        // Drop slot 0 if the newest window op absorbed it
        winNext[0].valid = winLinked ? fusedWin[`FUSE_WIDTH].valid : inUops[0].valid;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < `FUSE_WIDTH; i++) begin
                winQ[i].valid <= 1'b0;
                insQ[i].valid <= 1'b0;
            end
            winLinked <= 1'b0;
        end else if (!full) begin
            winQ <= winNext;
            insQ <= insNext;
            winLinked <= 1'b1;
        end else begin
            // A stalled edge breaks adjacency with the next accepted beat
            winLinked <= 1'b0;
        end
    end

    always_comb begin
        insBeat = insQ;
        for (int i = 0; i < `FUSE_WIDTH; i++) begin
            insBeat[i].valid = insQ[i].valid && !full;
        end
    end

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ns

module tbClock #(
    parameter int periodNs    = 40,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== uopQueue.sv ====
`timescale 1ns/1ns
`include "fusion_defines.svh"

module uopQueue import fusionPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  uopBeatT  insBeat,
    input  queueCntT popCnt,
    output uopBeatT  headUops,
    output logic     full
);

    uopT      mem [`FUSE_DEPTH];
    queueCntT rdPtr;
    queueCntT wrPtr;
    queueCntT used;
    queueCntT insCnt;
    queueCntT wrAddr [`FUSE_WIDTH];
    queueCntT headAddr [`FUSE_WIDTH];
    queueCntT rdNext;
    queueCntT wrNext;
    queueCntT freeNext;

    // Valid slots are packed into consecutive entries
    always_comb begin
        insCnt = '0;
        for (int i = 0; i < `FUSE_WIDTH; i++) begin
            wrAddr[i] = wrPtr + insCnt;
            if (insBeat[i].valid) begin
                insCnt = insCnt + queueCntT'(1);
            end
        end
    end

    assign used = wrPtr - rdPtr;

    always_comb begin
        for (int i = 0; i < `FUSE_WIDTH; i++) begin
            headAddr[i] = rdPtr + queueCntT'(i);
            headUops[i] = mem[headAddr[i][QIDX_W-1:0]];
            headUops[i].valid = queueCntT'(i) < used;
        end
    end

    assign wrNext = wrPtr + insCnt;
    assign rdNext = rdPtr + popCnt;
    assign freeNext = queueCntT'(`FUSE_DEPTH) - (wrNext - rdNext);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            full <= 1'b0;
        end else begin
            rdPtr <= rdNext;
            wrPtr <= wrNext;
            full <= freeNext < queueCntT'(`FUSE_MARGIN);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `FUSE_WIDTH; i++) begin
            if (insBeat[i].valid) begin
                mem[wrAddr[i][QIDX_W-1:0]] <= insBeat[i];
            end
        end
    end

endmodule
